// File: bp_pkg.sv
package bp_pkg;

  // primary opcode, inst[31:26]; anything not named is a non-branch
  typedef enum logic [5:0] {
    JSR_GRP = 6'h1a,
    BR      = 6'h30,
    BSR     = 6'h34,
    BLBC    = 6'h38,
    BEQ     = 6'h39,
    BLT     = 6'h3a,
    BLE     = 6'h3b,
    BLBS    = 6'h3c,
    BNE     = 6'h3d,
    BGE     = 6'h3e,
    BGT     = 6'h3f
  } opcode_e;

  typedef enum logic [1:0] {
    NONE,
    COND,
    UNCOND
  } br_class_e;

  typedef enum logic [1:0] {
    INIT,    // clearing sweep
    IDLE,
    UPDATE,  // table write
    ACK
  } ctrl_state_e;

  typedef struct packed {
    logic [63:0] pc;
    logic [31:0] inst;
    logic        valid;
  } fetch_slot_t;

  typedef struct packed {
    logic        taken;
    logic        is_branch;
    logic [63:0] target;
  } bp_pred_t;

  typedef struct packed {
    logic [63:0] pc;
    logic        is_cond;
    logic        taken;   // resolved direction
    logic [63:0] target;
  } resolve_t;

  localparam logic [1:0] counter_reset_c = 2'b01;  // weakly not taken
  localparam int lane_count_c = 2;
  localparam int index_bits_c = 6;

  // table index sits right above the word offset, caller narrows it
  function automatic logic [63:0] pc_index(input logic [63:0] pc, input int unsigned index_bits);
    logic [63:0] mask;
    mask = (64'd1 << index_bits) - 64'd1;
    return (pc >> 2) & mask;
  endfunction

  // everything above the index
  function automatic logic [63:0] pc_tag(input logic [63:0] pc, input int unsigned index_bits);
    return pc >> (index_bits + 2);
  endfunction

endpackage

// File: bp_decode.sv
`timescale 1ns/10ps

module bp_decode #(
  parameter int lane_count = bp_pkg::lane_count_c
) (
  input  bp_pkg::fetch_slot_t [lane_count-1:0] slots,
  output bp_pkg::br_class_e   [lane_count-1:0] br_class
);

  bp_pkg::opcode_e [lane_count-1:0] opcode;

  always_comb begin
    for (int l = 0; l < lane_count; l++) begin
      opcode[l] = bp_pkg::opcode_e'(slots[l].inst[31:26]);
    end
  end

  // only the primary opcode is looked at
  always_comb begin
    for (int l = 0; l < lane_count; l++) begin
      br_class[l] = bp_pkg::NONE;
      if (slots[l].valid) begin
        case (opcode[l])
          bp_pkg::BLBC,
          bp_pkg::BEQ,
          bp_pkg::BLT,
          bp_pkg::BLE,
          bp_pkg::BLBS,
          bp_pkg::BNE,
          bp_pkg::BGE,
          bp_pkg::BGT: begin
            br_class[l] = bp_pkg::COND;
          end
          bp_pkg::BR,
          bp_pkg::BSR,
          bp_pkg::JSR_GRP: begin
            br_class[l] = bp_pkg::UNCOND;  // always taken, target from btb
          end
          default: begin
            br_class[l] = bp_pkg::NONE;
          end
        endcase
      end
    end
  end

endmodule

// File: bp_bht.sv
`timescale 1ns/10ps

module bp_bht #(
  parameter int lane_count = bp_pkg::lane_count_c,
  parameter int index_bits = bp_pkg::index_bits_c
) (
  input  logic                                clock,
  input  logic                                reset,
  input  bp_pkg::fetch_slot_t [lane_count-1:0] slots,
  output logic                [lane_count-1:0] msb,
  input  logic [63:0]                         lookup_pc,    // resolving branch
  output logic [1:0]                          old_counter,
  input  logic                                write_en,
  input  logic [index_bits-1:0]               write_index,
  input  logic [1:0]                          write_value
);

  localparam int entries = 2 ** index_bits;

  logic [1:0] counters [entries];
  logic [index_bits-1:0] lookup_index;

  // fetch lanes only need the direction bit
  for (genvar l = 0; l < lane_count; l++) begin : g_lane
    logic [index_bits-1:0] lane_index;

    assign lane_index = index_bits'(bp_pkg::pc_index(slots[l].pc, index_bits));
    assign msb[l]     = counters[lane_index][1];
  end

  // third port feeds the saturating update
  assign lookup_index = index_bits'(bp_pkg::pc_index(lookup_pc, index_bits));
  assign old_counter  = counters[lookup_index];

  always_ff @(posedge clock) begin
    if (write_en) begin
      counters[write_index] <= write_value;
    end
  end

  a_write_index_known : assert property (
    @(posedge clock) disable iff (reset)
    write_en |-> !$isunknown(write_index)
  ) else $error("bht write with unknown index");

endmodule

// File: bp_btb.sv
`timescale 1ns/10ps

module bp_btb #(
  parameter int lane_count = bp_pkg::lane_count_c,
  parameter int index_bits = bp_pkg::index_bits_c
) (
  input  logic                                clock,
  input  bp_pkg::fetch_slot_t [lane_count-1:0] slots,
  output logic                [lane_count-1:0] hit,
  output logic [lane_count-1:0][63:0]         target,
  input  logic                                write_en,
  input  logic [index_bits-1:0]               write_index,
  input  logic                                write_valid,
  input  logic [63:0]                         write_pc,
  input  logic [63:0]                         write_target
);

  localparam int entries  = 2 ** index_bits;
  localparam int tag_bits = 62 - index_bits;

  logic                entry_valid  [entries];
  logic [tag_bits-1:0] entry_tag    [entries];
  logic [63:0]         entry_target [entries];

  logic [tag_bits-1:0] write_tag;

  for (genvar l = 0; l < lane_count; l++) begin : g_lane
    logic [index_bits-1:0] lane_index;
    logic [tag_bits-1:0]   lane_tag;

    assign lane_index = index_bits'(bp_pkg::pc_index(slots[l].pc, index_bits));
    assign lane_tag   = tag_bits'(bp_pkg::pc_tag(slots[l].pc, index_bits));
    // direct mapped, one compare per lane
    assign hit[l]     = entry_valid[lane_index] && (entry_tag[lane_index] == lane_tag);
    assign target[l]  = entry_target[lane_index];
  end

  assign write_tag = tag_bits'(bp_pkg::pc_tag(write_pc, index_bits));

  always_ff @(posedge clock) begin
    if (write_en) begin
      entry_valid[write_index]  <= write_valid;
      entry_tag[write_index]    <= write_tag;
      entry_target[write_index] <= write_target;
    end
  end

endmodule

// File: bp_ctrl.sv
`timescale 1ns/10ps

module bp_ctrl #(
  parameter int lane_count = bp_pkg::lane_count_c,
  parameter int index_bits = bp_pkg::index_bits_c
) (
  input  logic                                clock,
  input  logic                                reset,
  input  bp_pkg::fetch_slot_t [lane_count-1:0] slots,
  input  bp_pkg::br_class_e   [lane_count-1:0] br_class,
  input  logic                [lane_count-1:0] bht_msb,
  input  logic                [lane_count-1:0] btb_hit,
  input  logic [lane_count-1:0][63:0]         btb_target,
  input  logic                                rollback,
  input  logic [63:0]                         rollback_target,
  input  logic                                resolve_req,
  input  bp_pkg::resolve_t                    resolve,
  output logic                                resolve_ack,
  output logic                                ready,
  output logic [63:0]                         lookup_pc,
  input  logic [1:0]                          old_counter,
  output logic                                bht_write_en,
  output logic [index_bits-1:0]               bht_write_index,
  output logic [1:0]                          bht_write_value,
  output logic                                btb_write_en,
  output logic [index_bits-1:0]               btb_write_index,
  output logic                                btb_write_valid,
  output logic [63:0]                         btb_write_pc,
  output logic [63:0]                         btb_write_target,
  output bp_pkg::bp_pred_t    [lane_count-1:0] pred
);

  bp_pkg::ctrl_state_e   state;
  bp_pkg::ctrl_state_e   next_state;
  logic [index_bits-1:0] sweep_index;
  logic [index_bits-1:0] resolve_index;
  logic [1:0]            new_counter;

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= bp_pkg::INIT;
      sweep_index <= '0;
    end else begin
      state <= next_state;
      if (state == bp_pkg::INIT) begin
        sweep_index <= sweep_index + 1'b1;
      end
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      bp_pkg::INIT:   if (sweep_index == '1) next_state = bp_pkg::IDLE;  // last entry
      bp_pkg::IDLE:   if (resolve_req) next_state = bp_pkg::UPDATE;
      bp_pkg::UPDATE: next_state = bp_pkg::ACK;  // single write cycle
      bp_pkg::ACK:    if (!resolve_req) next_state = bp_pkg::IDLE;
      default:        next_state = bp_pkg::INIT;
    endcase
  end

  assign ready       = (state != bp_pkg::INIT);
  assign resolve_ack = (state == bp_pkg::ACK);

  assign lookup_pc     = resolve.pc;
  assign resolve_index = index_bits'(bp_pkg::pc_index(resolve.pc, index_bits));

  // 2-bit saturating step
  always_comb begin
    new_counter = old_counter;
    if (resolve.taken && old_counter != 2'b11) begin
      new_counter = old_counter + 2'd1;
    end else if (!resolve.taken && old_counter != 2'b00) begin
      new_counter = old_counter - 2'd1;
    end
  end

  always_comb begin
    bht_write_en     = 1'b0;
    bht_write_index  = sweep_index;
    bht_write_value  = bp_pkg::counter_reset_c;
    btb_write_en     = 1'b0;
    btb_write_index  = sweep_index;
    btb_write_valid  = 1'b0;
    btb_write_pc     = '0;
    btb_write_target = '0;
    case (state)
      bp_pkg::INIT: begin
        bht_write_en = 1'b1;
        btb_write_en = 1'b1;  // clears valid
      end
      bp_pkg::UPDATE: begin
        bht_write_en     = resolve.is_cond;
        bht_write_index  = resolve_index;
        bht_write_value  = new_counter;
        btb_write_en     = resolve.taken;  // not taken keeps the old entry
        btb_write_index  = resolve_index;
        btb_write_valid  = 1'b1;
        btb_write_pc     = resolve.pc;
        btb_write_target = resolve.target;
      end
      default: begin
      end
    endcase
  end

  for (genvar l = 0; l < lane_count; l++) begin : g_pred
    logic [63:0] seq_pc;
    logic        dir_taken;
    logic        taken;

    assign seq_pc    = slots[l].pc + 64'd4;
    assign dir_taken = (br_class[l] == bp_pkg::UNCOND) ||
                       (br_class[l] == bp_pkg::COND && bht_msb[l]);
    assign taken     = ready && slots[l].valid && dir_taken && btb_hit[l];  // needs a target
    // rollback wins over anything the tables say
    assign pred[l] = '{
      taken:     rollback || taken,
      is_branch: slots[l].valid && (br_class[l] != bp_pkg::NONE),
      target:    rollback ? rollback_target : (taken ? btb_target[l] : seq_pc)
    };
  end

  a_ack_needs_req : assert property (
    @(posedge clock) disable iff (reset)
    $rose(resolve_ack) |-> resolve_req
  ) else $error("resolve_ack rose without resolve_req");

  // a resolve write belongs to a live request, never to the ACK phase
  a_no_write_in_ack : assert property (
    @(posedge clock) disable iff (reset)
    (ready && (bht_write_en || btb_write_en)) |-> (resolve_req && !resolve_ack)
  ) else $error("table write during ACK or without resolve_req");

endmodule

// File: bp_top.sv
`timescale 1ns/10ps

module bp_top #(
  parameter int lane_count = bp_pkg::lane_count_c,
  parameter int index_bits = bp_pkg::index_bits_c
) (
  input  logic                                clock,
  input  logic                                reset,
  input  bp_pkg::fetch_slot_t [lane_count-1:0] slots,
  input  logic                                rollback,
  input  logic [63:0]                         rollback_target,
  input  logic                                resolve_req,
  input  bp_pkg::resolve_t                    resolve,
  output logic                                resolve_ack,
  output logic                                ready,
  output bp_pkg::bp_pred_t    [lane_count-1:0] pred
);

  bp_pkg::br_class_e [lane_count-1:0] br_class;

  logic [lane_count-1:0]        bht_msb;
  logic [63:0]                  lookup_pc;
  logic [1:0]                   old_counter;
  logic                         bht_write_en;
  logic [index_bits-1:0]        bht_write_index;
  logic [1:0]                   bht_write_value;

  logic [lane_count-1:0]        btb_hit;
  logic [lane_count-1:0][63:0]  btb_target;
  logic                         btb_write_en;
  logic [index_bits-1:0]        btb_write_index;
  logic                         btb_write_valid;
  logic [63:0]                  btb_write_pc;
  logic [63:0]                  btb_write_target;

  bp_decode #(
    .lane_count (lane_count)
  ) u_decode (
    .slots    (slots),
    .br_class (br_class)
  );

  bp_bht #(
    .lane_count (lane_count),
    .index_bits (index_bits)
  ) u_bht (
    .clock       (clock),
    .reset       (reset),
    .slots       (slots),
    .msb         (bht_msb),
    .lookup_pc   (lookup_pc),
    .old_counter (old_counter),
    .write_en    (bht_write_en),
    .write_index (bht_write_index),
    .write_value (bht_write_value)
  );

  bp_btb #(
    .lane_count (lane_count),
    .index_bits (index_bits)
  ) u_btb (
    .clock        (clock),
    .slots        (slots),
    .hit          (btb_hit),
    .target       (btb_target),
    .write_en     (btb_write_en),
    .write_index  (btb_write_index),
    .write_valid  (btb_write_valid),
    .write_pc     (btb_write_pc),
    .write_target (btb_write_target)
  );

  bp_ctrl #(
    .lane_count (lane_count),
    .index_bits (index_bits)
  ) u_ctrl (
    .clock            (clock),
    .reset            (reset),
    .slots            (slots),
    .br_class         (br_class),
    .bht_msb          (bht_msb),
    .btb_hit          (btb_hit),
    .btb_target       (btb_target),
    .rollback         (rollback),
    .rollback_target  (rollback_target),
    .resolve_req      (resolve_req),
    .resolve          (resolve),
    .resolve_ack      (resolve_ack),
    .ready            (ready),
    .lookup_pc        (lookup_pc),
    .old_counter      (old_counter),
    .bht_write_en     (bht_write_en),
    .bht_write_index  (bht_write_index),
    .bht_write_value  (bht_write_value),
    .btb_write_en     (btb_write_en),
    .btb_write_index  (btb_write_index),
    .btb_write_valid  (btb_write_valid),
    .btb_write_pc     (btb_write_pc),
    .btb_write_target (btb_write_target),
    .pred             (pred)
  );

endmodule

// File: tb_bp.sv
`timescale 1ns/10ps

module tb_bp;

  localparam int lane_count     = 2;
  localparam int index_bits     = 6;
  localparam int entries        = 2 ** index_bits;
  localparam int reset_cycles   = 10;
  localparam int random_cycles  = 2500;
  localparam int timeout_cycles = reset_cycles + entries + 3000 + 500;
  // last three are plain non-branch opcodes
  localparam logic [5:0] op_pool [14] = '{bp_pkg::BR, bp_pkg::BSR, bp_pkg::JSR_GRP,
    bp_pkg::BLBC, bp_pkg::BEQ, bp_pkg::BLT, bp_pkg::BLE, bp_pkg::BLBS, bp_pkg::BNE,
    bp_pkg::BGE, bp_pkg::BGT, 6'h00, 6'h11, 6'h29};
  localparam bit train_taken [8] = '{1, 1, 0, 0, 0, 0, 1, 1};
  localparam bit train_pred  [8] = '{1, 1, 1, 0, 0, 0, 0, 1};  // starting from 01

  logic clock;
  logic reset;
  logic rollback;
  logic [63:0] rollback_target;
  logic resolve_req;
  logic resolve_ack;
  logic ready;
  bp_pkg::resolve_t resolve;
  bp_pkg::fetch_slot_t [lane_count-1:0] slots;
  bp_pkg::bp_pred_t [lane_count-1:0] pred;

  // reference tables
  logic [1:0]  m_counter [entries];
  logic        m_valid   [entries];
  logic [63:0] m_tag     [entries];
  logic [63:0] m_target  [entries];
  int   sweep_count;
  int   phase;  // 0 idle, 1 update, 2 ack
  logic exp_ack;

  integer seed;
  int   error_count;
  int   check_count;
  int   cycle_count;
  int   tick_count;
  int   hold_count;
  int   req_wait;
  logic ack_seen;
  logic directed;
  logic issue_pending;
  bp_pkg::resolve_t next_resolve;
  bp_pkg::fetch_slot_t [lane_count-1:0] dir_slots;
  logic dir_rollback;
  logic [63:0] dir_rollback_target;

  bp_top #(
    .lane_count (lane_count),
    .index_bits (index_bits)
  ) u_dut (
    .clock           (clock),
    .reset           (reset),
    .slots           (slots),
    .rollback        (rollback),
    .rollback_target (rollback_target),
    .resolve_req     (resolve_req),
    .resolve         (resolve),
    .resolve_ack     (resolve_ack),
    .ready           (ready),
    .pred            (pred)
  );

  always #2 clock = ~clock;

  function automatic int rand_below(input int n);
    return int'({$random(seed)} % n);
  endfunction

  // 4 indices x 2 tags, so lanes collide in both tables
  function automatic logic [63:0] pool_pc(input int k);
    logic [63:0] tag;
    tag = (k < 4) ? 64'h40 : 64'h12345;
    return (tag << (index_bits + 2)) | (64'((k % 4) * 13) << 2);
  endfunction

  function automatic int branch_class(input logic [31:0] inst);  // 0 none, 1 cond, 2 uncond
    logic [5:0] op;
    op = inst[31:26];
    if (op inside {bp_pkg::BR, bp_pkg::BSR, bp_pkg::JSR_GRP}) return 2;
    if (op inside {bp_pkg::BLBC, bp_pkg::BEQ, bp_pkg::BLT, bp_pkg::BLE, bp_pkg::BLBS,
                   bp_pkg::BNE, bp_pkg::BGE, bp_pkg::BGT}) return 1;
    return 0;
  endfunction

  task automatic apply_resolve(input bp_pkg::resolve_t r);
    logic [index_bits-1:0] idx;
    idx = r.pc[index_bits+1:2];
    if (r.is_cond && r.taken && m_counter[idx] != 2'b11) m_counter[idx] += 2'd1;
    if (r.is_cond && !r.taken && m_counter[idx] != 2'b00) m_counter[idx] -= 2'd1;
    if (r.taken) begin
      m_valid[idx]  = 1'b1;
      m_tag[idx]    = r.pc >> (index_bits + 2);
      m_target[idx] = r.target;
    end
  endtask

  // advance the reference at the edge, using the inputs the DUT samples there
  task automatic update_model();
    if (reset) begin
      sweep_count = 0;
      phase       = 0;
      exp_ack     = 1'b0;
    end else if (sweep_count < entries) begin
      m_counter[sweep_count] = bp_pkg::counter_reset_c;
      m_valid[sweep_count]   = 1'b0;
      sweep_count++;
    end else if (phase == 0) begin
      if (resolve_req) phase = 1;
    end else if (phase == 1) begin
      apply_resolve(resolve);  // tables written as UPDATE closes
      phase   = 2;
      exp_ack = 1'b1;
    end else if (!resolve_req) begin
      phase   = 0;
      exp_ack = 1'b0;
    end
  endtask

  task automatic drive_resolve();
    bp_pkg::resolve_t r;
    if (resolve_req && ack_seen) begin
      if (hold_count == 0) resolve_req <= 1'b0;
      else hold_count--;
    end else if (resolve_req) begin
      req_wait++;
      assert (req_wait < 100) else begin
        $display("handshake stuck: no resolve_ack within 100 cycles of resolve_req");
        error_count++;
      end
    end else if (!ack_seen && !reset && (directed ? issue_pending : rand_below(8) == 0)) begin
      r.pc      = pool_pc(rand_below(8));
      r.is_cond = (rand_below(4) != 0);
      r.taken   = (rand_below(8) < 5);
      r.target  = {$random(seed), $random(seed)} & ~64'h3;
      resolve       <= directed ? next_resolve : r;
      resolve_req   <= 1'b1;
      issue_pending = 1'b0;
      hold_count    = rand_below(4);  // keep req up a little after ack
      req_wait      = 0;
    end
  endtask

  task automatic drive_fetch();
    bp_pkg::fetch_slot_t [lane_count-1:0] s;
    for (int l = 0; l < lane_count; l++) begin
      s[l].pc    = pool_pc(rand_below(8));
      s[l].inst  = {op_pool[rand_below(14)], 26'($random(seed))};
      s[l].valid = (rand_below(8) != 0);
    end
    slots           <= directed ? dir_slots : s;
    rollback        <= directed ? dir_rollback : (rand_below(16) == 0);
    rollback_target <= directed ? dir_rollback_target : {$random(seed), $random(seed)};
  endtask

  task automatic check_outputs();
    logic [index_bits-1:0] idx;
    logic exp_ready;
    logic exp_taken;
    logic exp_branch;
    logic hit;
    logic [63:0] exp_target;
    exp_ready = (sweep_count == entries);
    check_count++;
    assert (ready === exp_ready && resolve_ack === exp_ack) else begin
      $display("error at %0t: ready %b ack %b, expected %b %b", $time, ready, resolve_ack,
               exp_ready, exp_ack);
      error_count++;
    end
    assert (!resolve_ack || ack_seen || resolve_req) else begin
      $display("handshake broken: resolve_ack rose while resolve_req was low");
      error_count++;
    end
    for (int l = 0; l < lane_count; l++) begin
      idx        = slots[l].pc[index_bits+1:2];
      hit        = m_valid[idx] && m_tag[idx] == (slots[l].pc >> (index_bits + 2));
      exp_branch = slots[l].valid && branch_class(slots[l].inst) != 0;
      exp_taken  = exp_ready && slots[l].valid && hit && (branch_class(slots[l].inst) == 2 ||
                   (branch_class(slots[l].inst) == 1 && m_counter[idx][1]));
      exp_target = exp_taken ? m_target[idx] : slots[l].pc + 64'd4;
      if (rollback) begin
        exp_taken  = 1'b1;
        exp_target = rollback_target;
      end
      assert (pred[l].taken === exp_taken && pred[l].is_branch === exp_branch &&
              pred[l].target === exp_target) else begin
        $display("error at %0t: lane %0d pred %b %b %h, expected %b %b %h", $time, l,
                 pred[l].taken, pred[l].is_branch, pred[l].target,
                 exp_taken, exp_branch, exp_target);
        error_count++;
      end
    end
  endtask

  task automatic tick();
    @(posedge clock);
    tick_count++;
    update_model();
    reset <= (tick_count < reset_cycles);
    drive_resolve();
    drive_fetch();
    @(negedge clock);  // outputs settled
    check_outputs();
    ack_seen = resolve_ack;
  endtask

  task automatic send_resolve(input bp_pkg::resolve_t r);
    next_resolve  = r;
    issue_pending = 1'b1;
    tick();
    while (issue_pending || resolve_req || ack_seen) tick();
  endtask

  task automatic expect_lane(input int l, input logic taken, input logic [63:0] target);
    check_count++;
    assert (pred[l].taken === taken && pred[l].target === target) else begin
      $display("error at %0t: lane %0d taken %b target %h, expected %b %h", $time, l,
               pred[l].taken, pred[l].target, taken, target);
      error_count++;
    end
  endtask

  initial begin
    logic [63:0] pc_a;
    logic [63:0] pc_b;
    logic [63:0] target_t;
    seed = 32'h4cc73d48;
    clock = 1'b0;
    reset = 1'b1;
    slots = '0;
    rollback = 1'b0;
    rollback_target = '0;
    resolve_req = 1'b0;
    resolve = '0;
    {error_count, check_count, tick_count, hold_count, req_wait, sweep_count, phase} = '0;
    {exp_ack, ack_seen, directed, issue_pending, dir_rollback} = '0;
    repeat (reset_cycles + entries + random_cycles) tick();

    // directed training on index 21, which the random pool never touches
    pc_a     = 64'h0000_0000_0040_0054;
    pc_b     = pc_a ^ 64'h0000_0100_0000_0000;  // same index, other tag
    target_t = 64'h0000_0000_0088_1000;
    dir_slots[0] = '{pc: pc_a, inst: {6'(bp_pkg::BEQ), 26'h0}, valid: 1'b1};
    dir_slots[1] = '{pc: pc_b, inst: {6'(bp_pkg::BEQ), 26'h0}, valid: 1'b1};
    dir_rollback_target = 64'h0000_0000_00dd_0000;
    directed = 1'b1;
    tick();
    while (resolve_req || ack_seen) tick();
    tick();
    expect_lane(0, 1'b0, pc_a + 64'd4);
    for (int i = 0; i < 8; i++) begin
      send_resolve('{pc: pc_a, is_cond: 1'b1, taken: train_taken[i], target: target_t});
      expect_lane(0, train_pred[i], train_pred[i] ? target_t : pc_a + 64'd4);
      expect_lane(1, 1'b0, pc_b + 64'd4);  // tag miss
    end
    dir_rollback = 1'b1;
    tick();
    expect_lane(0, 1'b1, dir_rollback_target);
    expect_lane(1, 1'b1, dir_rollback_target);
    dir_rollback = 1'b0;
    tick();

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout: run did not end within %0d cycles", timeout_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: bp.f
bp_pkg.sv
bp_decode.sv
bp_bht.sv
bp_btb.sv
bp_ctrl.sv
bp_top.sv
tb_bp.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_bp and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_bp -Mdir obj_dir -f bp.f
	./obj_dir/Vtb_bp | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
